/* adpcma_pkg.sv */
// ----------------------------------------
// shared constants for the ADPCM-A engine
// step and index tables follow the YM2610
// ADPCM-A decoder, 12-bit accumulator
// index_adj needs 5 bits to hold +9
// ----------------------------------------
`default_nettype none

package adpcma_pkg;

    localparam int num_ch    = 6;
    localparam int frame_len = 18;             // cen slots per output sample
    localparam logic [4:0] slot_out = 5'd9;    // mixed sample published here

    localparam int addr_w = 20;                // ROM byte address
    localparam int reg_w  = 12;                // start/end in 256-byte pages
    localparam int acc_w  = 12;
    localparam int pcm_w  = 16;

    localparam int step_max = 48;

    localparam logic [10:0] step_table [0:step_max] = '{
        11'd16,   11'd17,   11'd19,   11'd21,   11'd23,   11'd25,   11'd28,
        11'd31,   11'd34,   11'd37,   11'd41,   11'd45,   11'd50,   11'd55,
        11'd60,   11'd66,   11'd73,   11'd80,   11'd88,   11'd97,   11'd107,
        11'd118,  11'd130,  11'd143,  11'd157,  11'd173,  11'd190,  11'd209,
        11'd230,  11'd253,  11'd279,  11'd307,  11'd337,  11'd371,  11'd408,
        11'd449,  11'd494,  11'd544,  11'd598,  11'd658,  11'd724,  11'd796,
        11'd876,  11'd963,  11'd1060, 11'd1166, 11'd1282, 11'd1411, 11'd1552
    };

    // indexed by nibble magnitude, bits 2..0
    localparam logic signed [4:0] index_adj [0:7] = '{
        -5'sd1, -5'sd1, -5'sd1, -5'sd1,
        5'sd2,  5'sd5,  5'sd7,  5'sd9
    };

endpackage

`default_nettype wire

/* adpcma_addr_cnt.sv */
// ----------------------------------------
// channel k is served in slot k (0..5)
// end writes land in slots 6..11
// addr/roe_n are combinational from slot
// a channel stops after byte end*256+255
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module adpcma_addr_cnt (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            cen,
    input  wire [4:0]                      slot,
    input  wire [adpcma_pkg::reg_w-1:0]    addr_in,
    input  wire                            start_wr,
    input  wire                            end_wr,
    input  wire                            key_on,
    input  wire                            key_off,
    output logic [adpcma_pkg::addr_w-1:0]  addr,
    output logic                           nibble_sel,   // 1 = low nibble due
    output logic                           ch_on,
    output logic                           roe_n
);
    import adpcma_pkg::*;

    logic [reg_w-1:0]  start_reg [num_ch];
    logic [reg_w-1:0]  end_reg [num_ch];
    logic [addr_w-1:0] cur [num_ch];
    logic [num_ch-1:0] phase;
    logic [num_ch-1:0] on;
    logic              in_ch;
    logic              in_end;
    logic              last;
    logic [2:0]        ch;
    logic [2:0]        ch_e;
    logic [reg_w-1:0]  start_eff;

    always_comb begin
        in_ch      = slot < 5'(num_ch);
        in_end     = !in_ch && slot < 5'(2 * num_ch);
        ch         = slot[2:0];
        ch_e       = 3'(slot - 5'(num_ch));
        start_eff  = '0;
        addr       = '0;
        nibble_sel = 1'b0;
        ch_on      = 1'b0;
        last       = 1'b0;
        if (in_ch) begin
            start_eff  = start_wr ? addr_in : start_reg[ch];
            ch_on      = key_on || (on[ch] && !key_off);
            nibble_sel = !key_on && phase[ch];           // key-on restarts on high nibble
            addr       = key_on ? {start_eff, 8'h00} : cur[ch];
            last       = nibble_sel && addr == {end_reg[ch], 8'hff};
        end
        roe_n = !(ch_on && !nibble_sel);                 // fetch only for high nibble
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_ch; i++) begin
                start_reg[i] <= '0;
                end_reg[i]   <= '0;
                cur[i]       <= '0;
            end
            phase <= '0;
            on    <= '0;
        end else if (cen) begin
            if (in_ch) begin
                if (start_wr)
                    start_reg[ch] <= addr_in;
                on[ch] <= ch_on && !last;
                if (ch_on) begin
                    phase[ch] <= !nibble_sel;
                    cur[ch]   <= nibble_sel ? addr + 20'd1 : addr;  // next byte after low
                end
            end
            if (in_end && end_wr)
                end_reg[ch_e] <= addr_in;
        end
    end

endmodule

`default_nettype wire

/* adpcma_decoder.sv */
// ----------------------------------------
// one nibble per cen, channel given by ch
// start clears accumulator and step index
// before the nibble is applied
// off channels output zero, state held
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module adpcma_decoder (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire                                  cen,
    input  wire [2:0]                            ch,
    input  wire [3:0]                            nibble,
    input  wire                                  ch_on,
    input  wire                                  start,
    output logic signed [adpcma_pkg::acc_w-1:0]  pcm
);
    import adpcma_pkg::*;

    logic signed [acc_w-1:0] acc [num_ch];
    logic [5:0]              idx [num_ch];
    logic signed [acc_w-1:0] acc_base;
    logic [5:0]              idx_base;
    logic [14:0]             prod;
    logic [11:0]             delta;
    logic signed [acc_w+1:0] acc_sum;
    logic signed [acc_w-1:0] acc_next;
    logic signed [7:0]       idx_sum;
    logic [5:0]              idx_next;

    always_comb begin
        acc_base = start ? '0 : acc[ch];
        idx_base = start ? '0 : idx[ch];
        prod     = step_table[idx_base] * {nibble[2:0], 1'b1};  // step * (2m+1)
        delta    = 12'(prod >> 3);
        if (nibble[3])
            acc_sum = acc_base - $signed({2'b00, delta});
        else
            acc_sum = acc_base + $signed({2'b00, delta});

        // clamp to the 12-bit range
        if (acc_sum[acc_w+1:acc_w-1] == '0 || acc_sum[acc_w+1:acc_w-1] == '1)
            acc_next = acc_sum[acc_w-1:0];
        else if (acc_sum[acc_w+1])
            acc_next = {1'b1, {(acc_w-1){1'b0}}};
        else
            acc_next = {1'b0, {(acc_w-1){1'b1}}};

        idx_sum = $signed({2'b00, idx_base}) + index_adj[nibble[2:0]];
        if (idx_sum < 0)
            idx_next = '0;
        else if (idx_sum > step_max)
            idx_next = 6'(step_max);
        else
            idx_next = idx_sum[5:0];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_ch; i++) begin
                acc[i] <= '0;
                idx[i] <= '0;
            end
            pcm <= '0;
        end else if (cen) begin
            if (ch_on) begin
                acc[ch] <= acc_next;
                idx[ch] <= idx_next;
                pcm     <= acc_next;
            end else begin
                pcm <= '0;
            end
        end
    end

endmodule

`default_nettype wire

/* adpcma_gain.sv */
// ----------------------------------------
// lracl bit 7 left, bit 6 right, 4..0 level
// out = pcm * (level+1) * (atl+1) >>> 8
// a write is used in the same cen it lands
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module adpcma_gain (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire                                  cen,
    input  wire [2:0]                            ch,
    input  wire                                  lracl_wr,
    input  wire [7:0]                            lracl_in,
    input  wire [5:0]                            atl,
    input  wire signed [adpcma_pkg::acc_w-1:0]   pcm_in,
    output logic signed [adpcma_pkg::pcm_w-1:0]  pcm_l,
    output logic signed [adpcma_pkg::pcm_w-1:0]  pcm_r
);
    import adpcma_pkg::*;

    logic [7:0]              lr [num_ch];
    logic [7:0]              lr_cur;
    logic [5:0]              lvl_mul;
    logic [6:0]              atl_mul;
    logic signed [24:0]      prod;
    logic signed [pcm_w-1:0] scaled;

    always_comb begin
        if (lracl_wr)
            lr_cur = lracl_in;
        else
            lr_cur = (ch < 3'(num_ch)) ? lr[ch] : '0;   // idle pipeline slots
        lvl_mul = {1'b0, lr_cur[4:0]} + 6'd1;
        atl_mul = {1'b0, atl} + 7'd1;
        prod    = pcm_in * $signed({1'b0, lvl_mul}) * $signed({1'b0, atl_mul});
        scaled  = pcm_w'(prod >>> 8);                 // fits, max |x| is 2^14
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_ch; i++)
                lr[i] <= '0;
            pcm_l <= '0;
            pcm_r <= '0;
        end else if (cen) begin
            if (lracl_wr && ch < 3'(num_ch))
                lr[ch] <= lracl_in;
            pcm_l <= lr_cur[7] ? scaled : '0;
            pcm_r <= lr_cur[6] ? scaled : '0;
        end
    end

endmodule

`default_nettype wire

/* adpcma_mixer.sv */
// ----------------------------------------
// sums channel 0..5 in slots 3..8
// saturates and publishes in slot 9
// sample_stb lasts one clock per frame
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module adpcma_mixer (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire                                  cen,
    input  wire [4:0]                            slot,
    input  wire signed [adpcma_pkg::pcm_w-1:0]   pcm_in_l,
    input  wire signed [adpcma_pkg::pcm_w-1:0]   pcm_in_r,
    output logic signed [adpcma_pkg::pcm_w-1:0]  pcm_l,
    output logic signed [adpcma_pkg::pcm_w-1:0]  pcm_r,
    output logic                                 sample_stb
);
    import adpcma_pkg::*;

    logic signed [pcm_w+2:0] acc_l;      // room for six full-scale channels
    logic signed [pcm_w+2:0] acc_r;
    logic                    in_mix;

    function automatic logic signed [pcm_w-1:0] sat(input logic signed [pcm_w+2:0] v);
        if (v[pcm_w+2:pcm_w-1] == '0 || v[pcm_w+2:pcm_w-1] == '1)
            sat = v[pcm_w-1:0];
        else if (v[pcm_w+2])
            sat = {1'b1, {(pcm_w-1){1'b0}}};
        else
            sat = {1'b0, {(pcm_w-1){1'b1}}};
    endfunction

    assign in_mix = slot >= slot_out - 5'(num_ch) && slot < slot_out;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_l      <= '0;
            acc_r      <= '0;
            pcm_l      <= '0;
            pcm_r      <= '0;
            sample_stb <= 1'b0;
        end else begin
            sample_stb <= cen && slot == slot_out;
            if (cen && in_mix) begin
                acc_l <= acc_l + pcm_in_l;
                acc_r <= acc_r + pcm_in_r;
            end else if (cen && slot == slot_out) begin
                pcm_l <= sat(acc_l);
                pcm_r <= sat(acc_r);
                acc_l <= '0;                 // start next frame clean
                acc_r <= '0;
            end
        end
    end

    a_stb_single: assert property (
        @(posedge clk) disable iff (!rst_n) sample_stb |=> !sample_stb
    );

endmodule

`default_nettype wire

/* adpcma_drv.sv */
// ----------------------------------------
// 18-slot frame, slot counter resets to 0
// writes are held pending and applied to
// the frame starting at the next slot 0
// datain valid at the cen ending slot k
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module adpcma_drv (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire                                 cen,        // one-clock slot enable
    output wire [adpcma_pkg::addr_w-1:0]        addr,
    output wire                                 roe_n,
    input  wire [7:0]                           datain,
    input  wire [2:0]                           reg_ch,
    input  wire [adpcma_pkg::reg_w-1:0]         reg_data,
    input  wire                                 up_start,
    input  wire                                 up_end,
    input  wire                                 up_lracl,
    input  wire [7:0]                           lracl_in,
    input  wire                                 up_aon,
    input  wire [7:0]                           aon_cmd,    // bit 7 set means key-off
    input  wire [5:0]                           atl,
    output wire signed [adpcma_pkg::pcm_w-1:0]  pcm_l,
    output wire signed [adpcma_pkg::pcm_w-1:0]  pcm_r,
    output wire                                 sample_stb
);
    import adpcma_pkg::*;

    logic [4:0]              slot;
    logic [num_ch-1:0]       pend_start, pend_end, pend_lr, pend_on, pend_off;
    logic [num_ch-1:0]       act_start, act_end, act_lr, act_on, act_off;
    logic [num_ch-1:0]       reg_dec, on_set, off_set;
    logic [reg_w-1:0]        start_val [num_ch];
    logic [reg_w-1:0]        end_val [num_ch];
    logic [7:0]              lr_val [num_ch];
    logic [3:0]              lo_hold [num_ch];     // low nibble kept for next frame
    logic                    frame_end, in_ch, in_end, gain_ok;
    logic [2:0]              slot_ch, end_ch, dec_ch, gain_ch;
    logic                    dec_on, dec_start;
    logic [3:0]              nibble;
    logic                    key_on, key_off, start_wr, end_wr, nibble_sel, ch_on;
    logic [reg_w-1:0]        addr_in;
    logic signed [acc_w-1:0] pcm_dec;
    logic signed [pcm_w-1:0] gain_l, gain_r;

    always_comb begin
        reg_dec = '0;
        if (reg_ch < 3'(num_ch))
            reg_dec[reg_ch] = 1'b1;
        on_set    = (up_aon && !aon_cmd[7]) ? aon_cmd[num_ch-1:0] : '0;
        off_set   = (up_aon && aon_cmd[7]) ? aon_cmd[num_ch-1:0] : '0;
        frame_end = cen && slot == 5'(frame_len - 1);
        in_ch     = slot < 5'(num_ch);
        in_end    = !in_ch && slot < 5'(2 * num_ch);
        slot_ch   = slot[2:0];
        end_ch    = 3'(slot - 5'(num_ch));
        key_on    = in_ch && act_on[slot_ch];
        key_off   = in_ch && act_off[slot_ch];
        start_wr  = in_ch && act_start[slot_ch];
        end_wr    = in_end && act_end[end_ch];
        addr_in   = in_ch ? start_val[slot_ch] : end_val[end_ch];
        gain_ok   = gain_ch < 3'(num_ch);
    end

    // frame counter and command masks
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot       <= '0;
            pend_start <= '0;
            pend_end   <= '0;
            pend_lr    <= '0;
            pend_on    <= '0;
            pend_off   <= '0;
            act_start  <= '0;
            act_end    <= '0;
            act_lr     <= '0;
            act_on     <= '0;
            act_off    <= '0;
        end else begin
            if (cen)
                slot <= frame_end ? 5'd0 : slot + 5'd1;
            if (frame_end) begin
                act_start <= pend_start;
                act_end   <= pend_end;
                act_lr    <= pend_lr;
                act_on    <= pend_on;
                act_off   <= pend_off;
            end
            pend_start <= (frame_end ? '0 : pend_start) | (up_start ? reg_dec : '0);
            pend_end   <= (frame_end ? '0 : pend_end) | (up_end ? reg_dec : '0);
            pend_lr    <= (frame_end ? '0 : pend_lr) | (up_lracl ? reg_dec : '0);
            pend_on    <= ((frame_end ? '0 : pend_on) & ~off_set) | on_set;  // last one wins
            pend_off   <= ((frame_end ? '0 : pend_off) & ~on_set) | off_set;
        end
    end

    always_ff @(posedge clk) begin
        if (up_start && reg_ch < 3'(num_ch))
            start_val[reg_ch] <= reg_data;
        if (up_end && reg_ch < 3'(num_ch))
            end_val[reg_ch] <= reg_data;
        if (up_lracl && reg_ch < 3'(num_ch))
            lr_val[reg_ch] <= lracl_in;
        if (cen && ch_on && !nibble_sel)
            lo_hold[slot_ch] <= datain[3:0];
        if (cen)
            nibble <= nibble_sel ? lo_hold[slot_ch] : datain[7:4];
    end

    // channel carried down the pipeline, 7 marks an idle stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_ch    <= 3'd7;
            dec_on    <= 1'b0;
            dec_start <= 1'b0;
            gain_ch   <= 3'd7;
        end else if (cen) begin
            dec_ch    <= in_ch ? slot_ch : 3'd7;
            dec_on    <= ch_on;
            dec_start <= key_on;
            gain_ch   <= dec_ch;
        end
    end

    adpcma_addr_cnt i_addr_cnt (
        .clk(clk), .rst_n(rst_n), .cen(cen), .slot(slot), .addr_in(addr_in),
        .start_wr(start_wr), .end_wr(end_wr), .key_on(key_on), .key_off(key_off),
        .addr(addr), .nibble_sel(nibble_sel), .ch_on(ch_on), .roe_n(roe_n)
    );

    adpcma_decoder i_decoder (
        .clk(clk), .rst_n(rst_n), .cen(cen), .ch(dec_ch), .nibble(nibble),
        .ch_on(dec_on), .start(dec_start), .pcm(pcm_dec)
    );

    adpcma_gain i_gain (
        .clk(clk), .rst_n(rst_n), .cen(cen), .ch(gain_ch),
        .lracl_wr(gain_ok && act_lr[gain_ch]),
        .lracl_in(gain_ok ? lr_val[gain_ch] : 8'h00),
        .atl(atl), .pcm_in(pcm_dec), .pcm_l(gain_l), .pcm_r(gain_r)
    );

    adpcma_mixer i_mixer (
        .clk(clk), .rst_n(rst_n), .cen(cen), .slot(slot),
        .pcm_in_l(gain_l), .pcm_in_r(gain_r),
        .pcm_l(pcm_l), .pcm_r(pcm_r), .sample_stb(sample_stb)
    );

endmodule

`default_nettype wire

/* tb_adpcma.sv */
// ----------------------------------------
// drives adpcma_drv from a random 1 MB ROM
// expected samples come from a frame model
// register writes go out just after sample_stb
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_adpcma;
    import adpcma_pkg::*;

    localparam int cycle_limit = 6 * 600 * frame_len * 4 + 20000;

    logic              clk = 1'b0;
    logic              rst_n = 1'b0;
    logic              cen = 1'b0;
    logic [1:0]        cen_cnt = '0;
    logic [7:0]        datain = '0;
    logic [2:0]        reg_ch = '0;
    logic [11:0]       reg_data = '0;
    logic              up_start = 1'b0, up_end = 1'b0, up_lracl = 1'b0, up_aon = 1'b0;
    logic [7:0]        lracl_in = '0, aon_cmd = '0;
    logic [5:0]        atl = '0;
    wire [19:0]        addr;
    wire               roe_n, sample_stb;
    wire signed [15:0] pcm_l, pcm_r;

    logic [7:0]        rom [0:(1 << addr_w) - 1];
    int                seed, cycles, err_cnt, check_cnt, sat_cnt;
    int                test_cnt, fail_tests, test_err0;
    string             test_name = "";

    // model state per channel
    int                m_start [num_ch];
    int                m_end [num_ch];
    int                m_cur [num_ch];
    int                m_acc [num_ch];
    int                m_idx [num_ch];
    logic [7:0]        m_lr [num_ch] = '{default: '0};
    logic [3:0]        m_hold [num_ch] = '{default: '0};
    logic [num_ch-1:0] m_on = '0, m_phase = '0, pend_on = '0, pend_off = '0;
    int                m_atl, exp_l, exp_r;
    int                exp_addr [$];
    int                got_addr [$];

    adpcma_drv i_dut (
        .clk(clk), .rst_n(rst_n), .cen(cen), .addr(addr), .roe_n(roe_n), .datain(datain),
        .reg_ch(reg_ch), .reg_data(reg_data), .up_start(up_start), .up_end(up_end),
        .up_lracl(up_lracl), .lracl_in(lracl_in), .up_aon(up_aon), .aon_cmd(aon_cmd),
        .atl(atl), .pcm_l(pcm_l), .pcm_r(pcm_r), .sample_stb(sample_stb)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cen_cnt <= cen_cnt + 2'd1;
        cen     <= cen_cnt == 2'd3;        // one clock in four
        datain  <= rom[addr];              // ROM answers one clock after addr
        cycles  <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("Regression failed");
            $finish;
        end
    end

    always @(posedge clk) begin
        if (rst_n && cen && !roe_n)
            got_addr.push_back(int'(addr));
    end

    function automatic int clamp(input int v, input int lo, input int hi);
        return (v < lo) ? lo : ((v > hi) ? hi : v);
    endfunction

    // advances every channel by one frame, fills exp_l, exp_r and exp_addr
    function automatic void adpcma_model();
        int         nib;
        int         mag;
        int         delta;
        int         pcm;
        int         gain;
        int         sum_l;
        int         sum_r;
        logic [7:0] rdata;
        sum_l = 0;
        sum_r = 0;
        exp_addr.delete();
        for (int ch = 0; ch < num_ch; ch++) begin
            if (pend_on[ch]) begin
                m_on[ch]    = 1'b1;
                m_phase[ch] = 1'b0;
                m_cur[ch]   = m_start[ch] * 256;
                m_acc[ch]   = 0;
                m_idx[ch]   = 0;
            end else if (pend_off[ch]) begin
                m_on[ch] = 1'b0;
            end
            pcm = 0;
            if (m_on[ch]) begin
                if (!m_phase[ch]) begin            // high nibble needs a fresh byte
                    rdata = rom[m_cur[ch]];
                    exp_addr.push_back(m_cur[ch]);
                    m_hold[ch] = rdata[3:0];
                    nib = int'(rdata[7:4]);
                end else begin
                    nib = int'(m_hold[ch]);
                    if (m_cur[ch] == m_end[ch] * 256 + 255)
                        m_on[ch] = 1'b0;           // last nibble of the end page
                    m_cur[ch] = (m_cur[ch] + 1) % (1 << addr_w);
                end
                m_phase[ch] = !m_phase[ch];
                mag   = nib % 8;
                delta = int'(step_table[m_idx[ch]]) * (2 * mag + 1) / 8;
                m_acc[ch] = clamp((nib >= 8) ? m_acc[ch] - delta : m_acc[ch] + delta,
                                  -2048, 2047);
                m_idx[ch] = clamp(m_idx[ch] + int'(index_adj[mag]), 0, step_max);
                pcm = m_acc[ch];
            end
            gain = (pcm * (int'(m_lr[ch][4:0]) + 1) * (m_atl + 1)) >>> 8;
            sum_l += m_lr[ch][7] ? gain : 0;
            sum_r += m_lr[ch][6] ? gain : 0;
        end
        exp_l = clamp(sum_l, -32768, 32767);
        exp_r = clamp(sum_r, -32768, 32767);
        if (exp_l != sum_l || exp_r != sum_r)
            sat_cnt++;
    endfunction

    task automatic check(input string what, input int expected, input int actual);
        check_cnt++;
        if (expected != actual) begin
            err_cnt++;
            $display("FAIL %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
        end
    endtask

    // one model step and compare per published sample
    always @(posedge clk) begin
        if (rst_n && sample_stb) begin
            adpcma_model();
            check("pcm_l", exp_l, int'(pcm_l));
            check("pcm_r", exp_r, int'(pcm_r));
            check("fetch count", exp_addr.size(), got_addr.size());
            for (int i = 0; i < exp_addr.size() && i < got_addr.size(); i++)
                check("fetch addr", exp_addr[i], got_addr[i]);
            got_addr.delete();
            pend_on  = '0;
            pend_off = '0;
        end
    end

    task automatic wait_frames(input int n);
        repeat (n) begin
            @(posedge clk);
            while (!sample_stb)
                @(posedge clk);
        end
    endtask

    task automatic open_write_window();
        wait_frames(1);
        @(posedge clk);                        // one clock after the compare
    endtask

    task automatic write_channel(input int ch, input int st, input int en, input logic [7:0] lr);
        reg_ch   <= 3'(ch);
        reg_data <= 12'(st);
        up_start <= 1'b1;
        @(posedge clk);
        up_start <= 1'b0;
        reg_data <= 12'(en);
        up_end   <= 1'b1;
        @(posedge clk);
        up_end   <= 1'b0;
        lracl_in <= lr;
        up_lracl <= 1'b1;
        @(posedge clk);
        up_lracl <= 1'b0;
        m_start[ch] = st;
        m_end[ch]   = en;
        m_lr[ch]    = lr;
    endtask

    task automatic key_command(input logic off, input logic [5:0] mask);
        aon_cmd <= {off, 1'b0, mask};
        up_aon  <= 1'b1;
        @(posedge clk);
        up_aon  <= 1'b0;
        pend_on  = off ? pend_on & ~mask : pend_on | mask;
        pend_off = off ? pend_off | mask : pend_off & ~mask;
    endtask

    task automatic start_test(input string name);
        test_cnt++;
        test_name = name;
        test_err0 = err_cnt;
    endtask

    task automatic finish_test();
        if (err_cnt != test_err0)
            fail_tests++;
        $display("test %0d %s: %s, %0d errors", test_cnt, test_name,
                 (err_cnt == test_err0) ? "ok" : "failed", err_cnt - test_err0);
    endtask

    initial begin
        seed = 32'hb135eca7;
        for (int i = 0; i < (1 << addr_w); i++)
            rom[i] = 8'($random(seed));
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        start_test("reset state");
        wait_frames(4);
        finish_test();

        start_test("single channel");
        open_write_window();
        write_channel(0, 1, 1, 8'hdf);         // both sides, level 31
        atl <= 6'd63;
        m_atl = 63;
        key_command(1'b0, 6'h01);
        wait_frames(520);                      // 512 nibbles, then silence
        check("silence after end", 0, int'(pcm_l));
        finish_test();

        start_test("pan and level");
        open_write_window();
        write_channel(2, 3, 8'h40, 8'h8a);     // left only, level 10
        write_channel(4, 7, 8'h40, 8'h59);     // right only, level 25
        atl <= 6'd0;
        m_atl = 0;
        key_command(1'b0, 6'h14);
        wait_frames(50);
        for (int i = 1; i <= 3; i++) begin
            open_write_window();
            atl <= 6'(21 * i);
            m_atl = 21 * i;
            wait_frames(50);
        end
        finish_test();

        start_test("six channel saturation");
        sat_cnt = 0;
        open_write_window();
        for (int ch = 0; ch < num_ch; ch++)
            write_channel(ch, 16, 48, 8'hdf);  // same data on every channel
        atl <= 6'd63;
        m_atl = 63;
        key_command(1'b0, 6'h3f);
        wait_frames(150);
        if (sat_cnt == 0) begin
            err_cnt++;
            $display("six channel test never pushed the mix past the 16-bit range");
        end
        finish_test();

        start_test("key-off mid-stream");
        open_write_window();
        key_command(1'b1, 6'h15);
        wait_frames(20);
        open_write_window();
        key_command(1'b0, 6'h15);              // restart from the start page
        wait_frames(30);
        open_write_window();
        key_command(1'b1, 6'h3f);
        wait_frames(5);
        check("silence after key-off", 0, int'(pcm_l));
        check("silence after key-off", 0, int'(pcm_r));
        finish_test();

        start_test("address sequence");
        open_write_window();
        write_channel(1, 12'h0a0, 12'h0a0, 8'hc3);
        write_channel(3, 12'hfff, 12'hfff, 8'hc7);
        write_channel(5, 12'h234, 12'h234, 8'hcf);
        key_command(1'b0, 6'h02);
        open_write_window();
        key_command(1'b0, 6'h28);              // odd frame offset from channel 1
        wait_frames(64);
        finish_test();

        $display("tests %0d, failing %0d, checks %0d, errors %0d",
                 test_cnt, fail_tests, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
adpcma_pkg.sv
adpcma_addr_cnt.sv
adpcma_decoder.sv
adpcma_gain.sv
adpcma_mixer.sv
adpcma_drv.sv
tb_adpcma.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the ADPCM-A testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_adpcma \
    -f build.f -o sim_adpcma
./obj_dir/sim_adpcma | tee sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi
if ! grep -q "Regression passed" sim.log; then
    exit 1
fi
exit 0
